/* Bender.yml */
package:
  name: mesh_memory

sources:
  # Design sources in compile order
  - verilog/mesh_mem_pkg.sv
  - verilog/mesh_port.sv
  - verilog/mem_arbiter.sv
  - verilog/sram_sp.sv
  - verilog/mesh_memory.sv

  # Testbench sources
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/tb_checker.sv
      - tests/tb_mesh_memory.sv

/* project.f */
verilog/mesh_mem_pkg.sv
verilog/mesh_port.sv
verilog/mem_arbiter.sv
verilog/sram_sp.sv
verilog/mesh_memory.sv
tests/tb_clock.sv
tests/tb_checker.sv
tests/tb_mesh_memory.sv

/* tests/tb_checker.sv */
/*
 * Mesh memory checker
 * Mirrors accepted writes in a byte model, predicts every read
 * response and compares it with what each port returns
 */
`default_nettype none

module tb_checker (
   input  wire logic                                                    clk,
   input  wire logic                                                    rst_n,
   input  wire logic [mesh_mem_pkg::NUM_PORTS-1:0]                      access_in,
   input  wire mesh_mem_pkg::mesh_packet_t [mesh_mem_pkg::NUM_PORTS-1:0] packet_in,
   input  wire logic [mesh_mem_pkg::NUM_PORTS-1:0]                      wait_out,
   input  wire logic [mesh_mem_pkg::NUM_PORTS-1:0]                      access_out,
   input  wire mesh_mem_pkg::mesh_packet_t [mesh_mem_pkg::NUM_PORTS-1:0] packet_out,
   input  wire logic [mesh_mem_pkg::NUM_PORTS-1:0]                      wait_in,
   input  wire logic [31:0]                                             test_id,
   input  wire logic                                                    test_done,
   output int                                                           pending,
   output int                                                           n_pass,
   output int                                                           n_fail
);

   // Byte model, 1024 doublewords of 8 lanes
   logic [7:0]                 model [8192];
   mesh_mem_pkg::mesh_packet_t exp_q [mesh_mem_pkg::NUM_PORTS][$];
   mesh_mem_pkg::mesh_packet_t held_pkt [mesh_mem_pkg::NUM_PORTS];
   logic                       held [mesh_mem_pkg::NUM_PORTS];
   int                         errs;

   function automatic string test_name(input logic [31:0] id);
      case (id)
         32'd0:   return "reset";
         32'd1:   return "double_rw";
         32'd2:   return "sub_word";
         32'd3:   return "dual_port";
         32'd4:   return "back_pressure";
         32'd5:   return "random_mix";
         default: return "unknown";
      endcase
   endfunction

   task automatic report(input string msg);
      $display("Error in %s: %s", test_name(test_id), msg);
      errs++;
   endtask

   // Size code n covers 2**n lanes, aligned to its own size
   task automatic apply_write(input mesh_mem_pkg::mesh_packet_t pkt);
      logic [63:0] wd;
      int          lanes;
      int          first;
      int          base;
      int          b;
      lanes = 1 << pkt.datamode;
      first = int'(pkt.dstaddr[2:0]) & ~(lanes - 1);
      base  = int'(pkt.dstaddr[12:3]) * 8;
      wd    = {pkt.data, pkt.data};
      if (pkt.datamode == mesh_mem_pkg::DM_DOUBLE)
         wd = {pkt.upper.hi_data, pkt.data};
      for (b = first; b < first + lanes; b++)
         model[base + b] = wd[8*b +: 8];
   endtask

   // Reference response for a read request
   function automatic mesh_mem_pkg::mesh_packet_t expect_rsp(
      input mesh_mem_pkg::mesh_packet_t pkt
   );
      mesh_mem_pkg::mesh_packet_t e;
      logic [63:0]                dw;
      int                         base;
      int                         b;
      base = int'(pkt.dstaddr[12:3]) * 8;
      for (b = 0; b < 8; b++)
         dw[8*b +: 8] = model[base + b];
      e               = '0;
      e.write         = 1'b1;
      e.datamode      = pkt.datamode;
      e.ctrlmode      = pkt.ctrlmode;
      e.dstaddr       = pkt.upper.ret_addr;
      e.data          = pkt.dstaddr[2] ? dw[63:32] : dw[31:0];
      e.upper.hi_data = dw[63:32];
      return e;
   endfunction

   initial
   begin
      errs    = 0;
      n_pass  = 0;
      n_fail  = 0;
      pending = 0;
   end

   always @(posedge clk)
   begin
      int                         p;
      mesh_mem_pkg::mesh_packet_t e;
      for (p = 0; p < mesh_mem_pkg::NUM_PORTS; p++)
      begin
         // wait_out only answers a live request
         if (wait_out[p] && !access_in[p])
            report($sformatf("port %0d raised wait_out without a request", p));
         if (!rst_n)
         begin
            held[p] = 1'b0;
            if (access_out[p])
               report($sformatf("port %0d drove access_out during reset", p));
         end
         else
         begin
            // Stalled response stays put
            if (held[p] && (!access_out[p] || packet_out[p] !== held_pkt[p]))
               report($sformatf("port %0d changed its response under wait_in", p));
            held[p]     = access_out[p] & wait_in[p];
            held_pkt[p] = packet_out[p];
            // Accepted request
            if (access_in[p] && !wait_out[p])
            begin
               if (packet_in[p].write)
                  apply_write(packet_in[p]);
               else
                  exp_q[p].push_back(expect_rsp(packet_in[p]));
            end
            // Taken response, in request order
            if (access_out[p] && !wait_in[p])
            begin
               if (exp_q[p].size() == 0)
                  report($sformatf("port %0d returned a response nobody asked for", p));
               else
               begin
                  e = exp_q[p].pop_front();
                  if (packet_out[p] !== e)
                  begin
                     $display("Mismatch in %s, port %0d: expected %h, actual %h",
                              test_name(test_id), p, e, packet_out[p]);
                     errs++;
                  end
               end
            end
         end
      end
      if (test_done)
      begin
         for (p = 0; p < mesh_mem_pkg::NUM_PORTS; p++)
            if (exp_q[p].size() != 0)
            begin
               report($sformatf("port %0d still owed %0d responses", p, exp_q[p].size()));
               exp_q[p].delete();
            end
         $display("%s finished with %0d errors", test_name(test_id), errs);
         if (errs == 0)
            n_pass++;
         else
            n_fail++;
         errs = 0;
      end
      pending = 0;
      for (p = 0; p < mesh_mem_pkg::NUM_PORTS; p++)
         pending += exp_q[p].size();
   end

endmodule : tb_checker

`default_nettype wire

/* tests/tb_clock.sv */
/*
 * Testbench clock and reset
 * Clock period of 8, rst_n held low for four cycles
 */
`default_nettype none

module tb_clock (
   output logic clk,
   output logic rst_n
);

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Released on a falling edge after four rising edges
   initial
   begin
      rst_n = 1'b0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule : tb_clock

`default_nettype wire

/* tests/tb_mesh_memory.sv */
/*
 * Testbench top for the mesh memory endpoint
 * Directed and random requests on both ports with wait_in patterns
 */
`default_nettype none

module tb_mesh_memory;

   localparam int SEND_LIMIT  = 200;
   localparam int DRAIN_LIMIT = 400;

   logic                                                     clk;
   logic                                                     rst_n;
   logic [mesh_mem_pkg::NUM_PORTS-1:0]                       access_in;
   mesh_mem_pkg::mesh_packet_t [mesh_mem_pkg::NUM_PORTS-1:0] packet_in;
   logic [mesh_mem_pkg::NUM_PORTS-1:0]                       wait_out;
   logic [mesh_mem_pkg::NUM_PORTS-1:0]                       access_out;
   mesh_mem_pkg::mesh_packet_t [mesh_mem_pkg::NUM_PORTS-1:0] packet_out;
   logic [mesh_mem_pkg::NUM_PORTS-1:0]                       wait_in;
   logic [31:0]                                              test_id;
   logic                                                     test_done;
   int                                                       pending;
   int                                                       n_pass;
   int                                                       n_fail;
   integer                                                   seed;
   logic                                                     hung;
   logic                                                     stop_jitter;

   tb_clock tb_clock_i (.clk(clk), .rst_n(rst_n));

   mesh_memory mesh_memory_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_in    (wait_in)
   );

   tb_checker tb_checker_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_in    (wait_in),
      .test_id    (test_id),
      .test_done  (test_done),
      .pending    (pending),
      .n_pass     (n_pass),
      .n_fail     (n_fail)
   );

   task automatic report_hang(input string msg);
      $display("%s", msg);
      hung = 1'b1;
   endtask

   function automatic mesh_mem_pkg::mesh_packet_t make_pkt(
      input logic wr, input logic [1:0] dm, input logic [4:0] ctrl,
      input logic [31:0] addr, input logic [31:0] data, input logic [31:0] upper
   );
      mesh_mem_pkg::mesh_packet_t pkt;
      pkt.write          = wr;
      pkt.datamode       = dm;
      pkt.ctrlmode       = ctrl;
      pkt.dstaddr        = addr;
      pkt.data           = data;
      pkt.upper.ret_addr = upper;
      return pkt;
   endfunction

   // Called on a falling edge, returns on a falling edge
   task automatic send(input int p, input mesh_mem_pkg::mesh_packet_t pkt);
      int t;
      access_in[p] = 1'b1;
      packet_in[p] = pkt;
      t = 0;
      @(posedge clk);
      while (wait_out[p] && !hung)
      begin
         t++;
         if (t > SEND_LIMIT)
            report_hang($sformatf("Timeout: port %0d request was never accepted", p));
         else
            @(posedge clk);
      end
      @(negedge clk);
      access_in[p] = 1'b0;
   endtask

   // Random size, data and return address with an occasional idle cycle
   task automatic rand_reqs(input int p, input int n, input int wr_pct, input logic [31:0] amask);
      logic [31:0] r;
      logic [31:0] a;
      int          i;
      for (i = 0; i < n && !hung; i++)
      begin
         r = $random(seed);
         a = $random(seed);
         send(p, make_pkt(int'(r[7:0]) % 100 < wr_pct, r[9:8], r[14:10], a & amask,
                          $random(seed), $random(seed)));
         if (r[17:16] == 2'b00)
            @(negedge clk);
      end
   endtask

   task automatic jitter(input int p, input int pct);
      logic [31:0] r;
      int          t;
      for (t = 0; t < 20000 && !stop_jitter; t++)
      begin
         @(negedge clk);
         r = $random(seed);
         wait_in[p] = int'(r[7:0]) % 100 < pct;
      end
      wait_in[p] = 1'b0;
   endtask

   task automatic random_phase(input int n, input int wr0, input int wr1,
                               input logic [31:0] amask, input int bp0, input int bp1);
      stop_jitter = 1'b0;
      fork
         jitter(0, bp0);
         jitter(1, bp1);
         begin
            fork
               rand_reqs(0, n, wr0, amask);
               rand_reqs(1, n, wr1, amask);
            join
            stop_jitter = 1'b1;
         end
      join
   endtask

   // Wait for every response, then close the test
   task automatic end_test();
      int t;
      t = 0;
      while (pending != 0 && !hung)
      begin
         t++;
         if (t > DRAIN_LIMIT)
            report_hang("Timeout: responses still outstanding at the end of a test");
         else
            @(negedge clk);
      end
      test_done = 1'b1;
      @(negedge clk);
      test_done = 1'b0;
   endtask

   task automatic run_tests();
      logic [31:0] r;
      logic [31:0] addr;
      logic [1:0]  dm;
      int          i;
      int          t;
      int          step;
      int          off;
      int          p;
      // Outputs stay quiet through reset
      test_id = 0;
      t = 0;
      while (!rst_n && !hung)
      begin
         t++;
         if (t > 20)
            report_hang("Timeout: reset was never released");
         else
            @(negedge clk);
      end
      repeat (4) @(negedge clk);
      end_test();
      // Fill doublewords 0 to 31, then read both halves back
      test_id = 1;
      for (i = 0; i < 32; i++)
      begin
         r = 32'ha5c3_0f00 ^ (i * 32'h0001_0203);
         send(0, make_pkt(1'b1, mesh_mem_pkg::DM_DOUBLE, 5'h0, i * 8, r,
                          (i * 32'h0301_0007) + 32'h1e2d_3c4b));
      end
      for (i = 0; i < 4; i++)
         send(0, make_pkt(1'b0, mesh_mem_pkg::DM_DOUBLE, 5'h15 ^ i[4:0],
                          (i < 2 ? 5 : 31) * 8 + (i % 2) * 4, 32'h0, 32'hc000_0100 + i));
      end_test();
      // Byte, short and word at every lane offset on alternating ports
      // Read back at the low half so data and upper cover all eight lanes
      test_id = 2;
      for (step = 1; step <= 4; step = step * 2)
      begin
         for (off = 0; off < 8; off = off + step)
         begin
            dm   = 2'(step / 2);
            addr = 32'((2 + step) * 8 + off);
            r    = $random(seed);
            p    = (off / step) % 2;
            send(p, make_pkt(1'b1, dm, 5'h0, addr, r, 32'h0));
            send(p, make_pkt(1'b0, mesh_mem_pkg::DM_DOUBLE, r[4:0], addr & 32'hffff_fff8,
                             32'h0, r ^ 32'h5555_0000));
         end
      end
      end_test();
      // Both ports on a few shared doublewords
      test_id = 3;
      random_phase(24, 50, 50, 32'h1f, 0, 0);
      end_test();
      // Port 1 streams reads under heavy back-pressure
      test_id = 4;
      random_phase(40, 30, 0, 32'hff, 0, 60);
      end_test();
      // 400 requests over both ports
      test_id = 5;
      random_phase(200, 40, 40, 32'hff, 30, 30);
      end_test();
   endtask

   initial
   begin
      access_in   = '0;
      packet_in   = '0;
      wait_in     = '0;
      test_id     = '0;
      test_done   = 1'b0;
      hung        = 1'b0;
      stop_jitter = 1'b0;
      seed        = 32'hbfc2_ec21;
      fork
         run_tests();
         wait (hung);
      join_any
      disable fork;
      $display("Summary: pass count %0d, fail count %0d", n_pass, n_fail);
      if (!hung && n_fail == 0 && n_pass == 6)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule : tb_mesh_memory

`default_nettype wire

/* verilog/mem_arbiter.sv */
/*
 * Round-robin memory arbiter
 * Grants one raised request per cycle and forwards it to the SRAM
 */
`default_nettype none

module mem_arbiter (
   input  wire logic                                                clk,
   input  wire logic                                                rst_n,
   input  wire mesh_mem_pkg::mem_req_t [mesh_mem_pkg::NUM_PORTS-1:0] reqs,
   output logic [mesh_mem_pkg::NUM_PORTS-1:0]                       grants,
   output mesh_mem_pkg::mem_req_t                                   mem_req
);

   localparam int IW = (mesh_mem_pkg::NUM_PORTS > 1) ? $clog2(mesh_mem_pkg::NUM_PORTS) : 1;

   logic [IW-1:0] last_q;
   logic [IW-1:0] win;
   logic          any;
   int            cand;

   // Search from the port after the last winner
   // Lowest distance is checked last so it wins
   always_comb
   begin
      win  = last_q;
      any  = 1'b0;
      cand = 0;
      for (int i = mesh_mem_pkg::NUM_PORTS; i >= 1; i--)
      begin
         cand = (int'(last_q) + i) % mesh_mem_pkg::NUM_PORTS;
         if (reqs[cand].en)
         begin
            win = IW'(cand);
            any = 1'b1;
         end
      end
   end

   always_comb
   begin
      grants      = '0;
      grants[win] = any;
      mem_req     = reqs[win];
      mem_req.en  = any;
   end

   // Last winner, reset so port 0 goes first
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         last_q <= IW'(mesh_mem_pkg::NUM_PORTS - 1);
      end
      else if (any)
      begin
         last_q <= win;
      end
   end

endmodule : mem_arbiter

`default_nettype wire

/* verilog/mesh_mem_pkg.sv */
/*
 * Mesh memory endpoint definitions
 * Packet layout, size codes, memory geometry and the per-port
 * memory access passed between the mesh ports, arbiter and SRAM
 */
`default_nettype none

package mesh_mem_pkg;

   // Number of mesh ports sharing the memory
   localparam int NUM_PORTS = 2;

   // Doubleword address width, 1024 x 64 bits
   localparam int MEM_AW = 10;

   // Transfer size codes carried in datamode
   localparam logic [1:0] DM_BYTE   = 2'd0;
   localparam logic [1:0] DM_SHORT  = 2'd1;
   localparam logic [1:0] DM_WORD   = 2'd2;
   localparam logic [1:0] DM_DOUBLE = 2'd3;

   // Upper packet word
   // Read requests carry the return address here,
   // double writes carry the high 32 data bits
   typedef union packed {
      logic [31:0] ret_addr;
      logic [31:0] hi_data;
   } mesh_upper_t;

   // 104-bit mesh packet, write bit at the top
   typedef struct packed {
      logic        write;
      logic [1:0]  datamode;
      logic [4:0]  ctrlmode;
      logic [31:0] dstaddr;
      logic [31:0] data;
      mesh_upper_t upper;
   } mesh_packet_t;

   // One port's memory access
   // en qualifies the whole access, wen is zero for reads
   typedef struct packed {
      logic              en;
      logic [7:0]        wen;
      logic [MEM_AW-1:0] addr;
      logic [63:0]       wdata;
   } mem_req_t;

endpackage : mesh_mem_pkg

`default_nettype wire

/* verilog/mesh_memory.sv */
/*
 * Mesh memory endpoint top
 * Two mesh ports share one SRAM through a round-robin arbiter
 */
`default_nettype none

module mesh_memory (
   input  wire logic                                                    clk,
   input  wire logic                                                    rst_n,
   input  wire logic [mesh_mem_pkg::NUM_PORTS-1:0]                      access_in,
   input  wire mesh_mem_pkg::mesh_packet_t [mesh_mem_pkg::NUM_PORTS-1:0] packet_in,
   output logic [mesh_mem_pkg::NUM_PORTS-1:0]                           wait_out,
   output logic [mesh_mem_pkg::NUM_PORTS-1:0]                           access_out,
   output mesh_mem_pkg::mesh_packet_t [mesh_mem_pkg::NUM_PORTS-1:0]     packet_out,
   input  wire logic [mesh_mem_pkg::NUM_PORTS-1:0]                      wait_in
);

   mesh_mem_pkg::mem_req_t [mesh_mem_pkg::NUM_PORTS-1:0] port_req;
   logic [mesh_mem_pkg::NUM_PORTS-1:0]                   grants;
   mesh_mem_pkg::mem_req_t                               mem_req;
   logic [63:0]                                          rdata;

   // One endpoint per mesh port
   for (genvar p = 0; p < mesh_mem_pkg::NUM_PORTS; p++)
   begin : g_port
      mesh_port mesh_port_i (
         .clk        (clk),
         .rst_n      (rst_n),
         .access_in  (access_in[p]),
         .packet_in  (packet_in[p]),
         .wait_out   (wait_out[p]),
         .access_out (access_out[p]),
         .packet_out (packet_out[p]),
         .wait_in    (wait_in[p]),
         .req        (port_req[p]),
         .grant      (grants[p]),
         .rdata      (rdata)
      );
   end

   mem_arbiter mem_arbiter_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .reqs    (port_req),
      .grants  (grants),
      .mem_req (mem_req)
   );

   // Shared read data goes to both ports
   sram_sp sram_sp_i (
      .clk     (clk),
      .mem_req (mem_req),
      .rdata   (rdata)
   );

endmodule : mesh_memory

`default_nettype wire

/* verilog/mesh_port.sv */
/*
 * Mesh port
 * Decodes a mesh request into a 64-bit memory access with byte
 * mask, requests the shared memory and returns read data as a
 * response packet through a two-entry return buffer
 */
`default_nettype none

module mesh_port (
   input  wire logic                         clk,
   input  wire logic                         rst_n,
   // Requests from the mesh
   input  wire logic                         access_in,
   input  wire mesh_mem_pkg::mesh_packet_t   packet_in,
   output logic                              wait_out,
   // Responses to the mesh
   output logic                              access_out,
   output mesh_mem_pkg::mesh_packet_t        packet_out,
   input  wire logic                         wait_in,
   // Memory side
   output mesh_mem_pkg::mem_req_t            req,
   input  wire logic                         grant,
   input  wire logic [63:0]                  rdata
);

   // Response fields saved while the read is in flight
   typedef struct packed {
      logic [1:0]  datamode;
      logic [4:0]  ctrlmode;
      logic [31:0] ret_addr;
      logic        hsel;
   } rsp_info_t;

   logic [7:0]                 mask;
   logic                       room;
   logic                       pop;
   logic                       push;
   logic                       rd_pend;
   rsp_info_t                  info;
   mesh_mem_pkg::mesh_packet_t rsp;
   mesh_mem_pkg::mesh_packet_t rbuf [2];
   logic [1:0]                 cnt;
   logic                       wr_ptr;
   logic                       rd_ptr;

   // Byte lanes touched by the request
   always_comb
   begin
      case (packet_in.datamode)
         mesh_mem_pkg::DM_BYTE:  mask = 8'h01 << packet_in.dstaddr[2:0];
         mesh_mem_pkg::DM_SHORT: mask = 8'h03 << {packet_in.dstaddr[2:1], 1'b0};
         mesh_mem_pkg::DM_WORD:  mask = 8'h0f << {packet_in.dstaddr[2], 2'b00};
         default:                mask = 8'hff;
      endcase
   end

   // Return buffer and in-flight read must leave a free slot
   // A response leaving this cycle frees its entry
   assign pop  = access_out & ~wait_in;
   assign room = ({1'b0, cnt} + {2'b00, rd_pend}) < (3'd2 + {2'b00, pop});

   // Memory access
   always_comb
   begin
      req.en   = access_in & (packet_in.write | room);
      req.wen  = packet_in.write ? mask : 8'h00;
      req.addr = packet_in.dstaddr[mesh_mem_pkg::MEM_AW+2:3];
      // Double puts the upper word on top, smaller sizes are mirrored
      if (packet_in.datamode == mesh_mem_pkg::DM_DOUBLE)
      begin
         req.wdata = {packet_in.upper.hi_data, packet_in.data};
      end
      else
      begin
         req.wdata = {packet_in.data, packet_in.data};
      end
   end

   // Stall until granted
   assign wait_out = access_in & ~grant;

   // In-flight read flag
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         rd_pend <= 1'b0;
      end
      else
      begin
         rd_pend <= grant & ~packet_in.write;
      end
   end

   // Fields needed to build the response
   always_ff @(posedge clk)
   begin
      if (grant && !packet_in.write)
      begin
         info.datamode <= packet_in.datamode;
         info.ctrlmode <= packet_in.ctrlmode;
         info.ret_addr <= packet_in.upper.ret_addr;
         info.hsel     <= packet_in.dstaddr[2];
      end
   end

   // Merge saved fields with read data
   always_comb
   begin
      rsp                = '0;
      rsp.write          = 1'b1;
      rsp.datamode       = info.datamode;
      rsp.ctrlmode       = info.ctrlmode;
      rsp.dstaddr        = info.ret_addr;
      rsp.data           = info.hsel ? rdata[63:32] : rdata[31:0];
      rsp.upper.hi_data  = rdata[63:32];
   end

   assign push = rd_pend;

   // Return buffer pointers and fill level
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         cnt    <= 2'd0;
         wr_ptr <= 1'b0;
         rd_ptr <= 1'b0;
      end
      else
      begin
         cnt <= cnt + {1'b0, push} - {1'b0, pop};
         if (push)
         begin
            wr_ptr <= ~wr_ptr;
         end
         if (pop)
         begin
            rd_ptr <= ~rd_ptr;
         end
      end
   end

   // Buffer storage
   always_ff @(posedge clk)
   begin
      if (push)
      begin
         rbuf[wr_ptr] <= rsp;
      end
   end

   // Head entry stays put while wait_in is high
   assign access_out = (cnt != 2'd0);
   assign packet_out = rbuf[rd_ptr];

endmodule : mesh_port

`default_nettype wire

/* verilog/sram_sp.sv */
/*
 * Single-port SRAM, 64 bits wide
 * Byte write enables, registered read one cycle after enable
 */
`default_nettype none

module sram_sp (
   input  wire logic                   clk,
   input  wire mesh_mem_pkg::mem_req_t mem_req,
   output logic [63:0]                 rdata
);

   localparam int DEPTH = 2 ** mesh_mem_pkg::MEM_AW;

   logic [63:0] mem [DEPTH];

   // Lane writes
   always_ff @(posedge clk)
   begin
      if (mem_req.en)
      begin
         for (int b = 0; b < 8; b++)
         begin
            if (mem_req.wen[b])
            begin
               mem[mem_req.addr][8*b +: 8] <= mem_req.wdata[8*b +: 8];
            end
         end
      end
   end

   // Read returns the old contents on a write cycle
   always_ff @(posedge clk)
   begin
      if (mem_req.en)
      begin
         rdata <= mem[mem_req.addr];
      end
   end

endmodule : sram_sp

`default_nettype wire
